//--- stream_pe_pkg.sv
package stream_pe_pkg;

    // array geometry, one column of processing elements per stream lane
    localparam int num_col = 4;
    localparam int lane_w = 16;
    // full width of one stream beat across all lanes
    localparam int phit_size = num_col * lane_w;

    // configuration table, one entry is consumed per accepted beat
    localparam int cfg_depth = 16;
    localparam int cfg_addr_w = $clog2(cfg_depth);

    // per-column register file
    localparam int rf_depth = 8;
    localparam int rf_addr_w = $clog2(rf_depth);

    // the immediate is zero-extended up to the lane width inside the column
    localparam int imm_w = 8;

    // alu operations, sub is always lane minus operand
    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_xor  = 2'd2,
        op_pass = 2'd3
    } op_e;

    // second operand sources
    typedef enum logic [1:0] {
        sel_rf   = 2'd0,
        sel_imm  = 2'd1,
        sel_itr  = 2'd2,
        sel_left = 2'd3
    } sel_e;

    // one 20-bit configuration entry for a single column
    typedef struct packed {
        logic                 valid;
        op_e                  op;
        sel_e                 sel;
        logic                 rf_wr_en;
        logic [rf_addr_w-1:0] rf_wr_addr;
        logic [rf_addr_w-1:0] rf_rd_addr;
        logic [imm_w-1:0]     imm;
    } cfg_entry_t;

    // host write, the mask picks which columns take the entry
    typedef struct packed {
        logic [num_col-1:0]    en;
        logic [cfg_addr_w-1:0] addr;
        cfg_entry_t            entry;
    } cfg_wr_t;

    // lane 0 sits in the least significant bits
    typedef logic [num_col-1:0][lane_w-1:0] stream_word_t;

    // register file clear write, applied to every column at once
    typedef struct packed {
        logic                 en;
        logic [rf_addr_w-1:0] addr;
    } rf_clear_t;

    // beat handed from the sequencer to the data path
    typedef struct packed {
        logic              valid;
        stream_word_t      data;
        logic [lane_w-1:0] itr;
    } stage_t;

endpackage

//--- stream_sequencer.sv
module stream_sequencer (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  start_loader,
    input  logic [stream_pe_pkg::cfg_addr_w-1:0]  cfg_last_entry,
    input  logic [stream_pe_pkg::rf_addr_w:0]     rf_clear_count,
    input  logic                                  start_stream_in,
    input  stream_pe_pkg::stream_word_t           stream_in,
    output logic                                  ready_stream_in,
    output logic [stream_pe_pkg::cfg_addr_w-1:0]  rd_addr,
    output stream_pe_pkg::rf_clear_t              rf_clear,
    output stream_pe_pkg::stage_t                 stage
);

    // idle until the first load, then clear the register files, then stream
    typedef enum logic [1:0] {
        st_idle,
        st_clear,
        st_stream
    } state_e;

    state_e                                state_q;
    logic [stream_pe_pkg::cfg_addr_w-1:0]  last_entry_q;
    logic [stream_pe_pkg::cfg_addr_w-1:0]  ptr_q;
    logic [stream_pe_pkg::rf_addr_w:0]     clear_cnt_q;
    logic [stream_pe_pkg::rf_addr_w-1:0]   clear_addr_q;
    logic [stream_pe_pkg::lane_w-1:0]      itr_q;
    logic                                  stage_valid_q;
    logic [stream_pe_pkg::phit_size-1:0]   stage_data_q;
    logic [stream_pe_pkg::lane_w-1:0]      stage_itr_q;
    logic                                  accept;
    logic                                  clear_last;

    // ready is a level, start is the per-beat strobe
    assign ready_stream_in = (state_q == st_stream);
    assign accept = start_stream_in && ready_stream_in;

    // the last clear address is one below the sampled count
    assign clear_last = (({1'b0, clear_addr_q} + 1'b1) == clear_cnt_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= st_idle;
            last_entry_q <= '0;
            clear_cnt_q  <= '0;
            clear_addr_q <= '0;
            ptr_q        <= '0;
            itr_q        <= '0;
        end else if (start_loader) begin
            // a new load phase restarts the pass over the table from entry 0
            last_entry_q <= cfg_last_entry;
            clear_cnt_q  <= rf_clear_count;
            clear_addr_q <= '0;
            ptr_q        <= '0;
            itr_q        <= '0;
            // with nothing to clear we go straight to streaming
            state_q      <= (rf_clear_count == '0) ? st_stream : st_clear;
        end else begin
            case (state_q)
                st_clear: begin
                    clear_addr_q <= clear_addr_q + 1'b1;
                    if (clear_last) begin
                        state_q <= st_stream;
                    end
                end
                st_stream: begin
                    if (accept) begin
                        // wrap after the last entry and count one finished pass
                        if (ptr_q == last_entry_q) begin
                            ptr_q <= '0;
                            itr_q <= itr_q + 1'b1;
                        end else begin
                            ptr_q <= ptr_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // the stage valid bit tracks every accept so beats keep draining
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= accept;
        end
    end

    // itr here is the count before the wrap increment of the same edge
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_data_q <= stream_in;
            stage_itr_q  <= itr_q;
        end
    end

    // the table registers the entry at this address on the accept edge too
    assign rd_addr = ptr_q;

    assign rf_clear.en   = (state_q == st_clear);
    assign rf_clear.addr = clear_addr_q;

    assign stage.valid = stage_valid_q;
    assign stage.data  = stage_data_q;
    assign stage.itr   = stage_itr_q;

endmodule

//--- config_table.sv
module config_table (
    input  logic                                                 clk,
    input  stream_pe_pkg::cfg_wr_t                               cfg_wr,
    input  logic [stream_pe_pkg::cfg_addr_w-1:0]                 rd_addr,
    output stream_pe_pkg::cfg_entry_t [stream_pe_pkg::num_col-1:0] entries
);

    // one independent table per column, all indexed by the same address
    stream_pe_pkg::cfg_entry_t mem_q [stream_pe_pkg::num_col][stream_pe_pkg::cfg_depth];

    // host writes land only in the columns selected by the mask
    always_ff @(posedge clk) begin
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            if (cfg_wr.en[c]) begin
                mem_q[c][cfg_wr.addr] <= cfg_wr.entry;
            end
        end
    end

    // registered read every cycle
    // this lines the entries up with the beat held in the sequencer stage
    always_ff @(posedge clk) begin
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            entries[c] <= mem_q[c][rd_addr];
        end
    end

endmodule

//--- pe_column.sv
module pe_column (
    input  logic                              clk,
    input  logic                              arst_n,
    input  stream_pe_pkg::cfg_entry_t         entry,
    input  logic [stream_pe_pkg::lane_w-1:0]  lane,
    input  logic [stream_pe_pkg::lane_w-1:0]  left_lane,
    input  logic [stream_pe_pkg::lane_w-1:0]  itr,
    input  logic                              stage_valid,
    input  stream_pe_pkg::rf_clear_t          rf_clear,
    output logic [stream_pe_pkg::lane_w-1:0]  result
);

    logic [stream_pe_pkg::lane_w-1:0] rf_q [stream_pe_pkg::rf_depth];
    logic [stream_pe_pkg::lane_w-1:0] operand;
    logic [stream_pe_pkg::lane_w-1:0] alu_out;
    logic [stream_pe_pkg::lane_w-1:0] result_d;
    logic                             rf_wr;

    // second operand mux
    // the register file read is combinational so a beat sees earlier write-backs
    always_comb begin
        operand = '0;
        case (entry.sel)
            stream_pe_pkg::sel_rf: begin
                operand = rf_q[entry.rf_rd_addr];
            end
            stream_pe_pkg::sel_imm: begin
                operand = {{(stream_pe_pkg::lane_w - stream_pe_pkg::imm_w){1'b0}}, entry.imm};
            end
            stream_pe_pkg::sel_itr: begin
                operand = itr;
            end
            stream_pe_pkg::sel_left: begin
                // left neighbor's input lane of this beat, not its result
                operand = left_lane;
            end
            default: begin
                operand = '0;
            end
        endcase
    end

    // alu, the own lane is always the first operand
    always_comb begin
        alu_out = '0;
        case (entry.op)
            stream_pe_pkg::op_add: begin
                alu_out = lane + operand;
            end
            stream_pe_pkg::op_sub: begin
                alu_out = lane - operand;
            end
            stream_pe_pkg::op_xor: begin
                alu_out = lane ^ operand;
            end
            stream_pe_pkg::op_pass: begin
                alu_out = operand;
            end
            default: begin
                alu_out = lane;
            end
        endcase
    end

    // an invalid entry leaves the lane untouched
    assign result_d = entry.valid ? alu_out : lane;

    // write-back only for a live beat with a valid, write-enabled entry
    assign rf_wr = stage_valid && entry.valid && entry.rf_wr_en;

    // clears and stream writes never meet, clears run while ready is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < stream_pe_pkg::rf_depth; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_clear.en) begin
            rf_q[rf_clear.addr] <= '0;
        end else if (rf_wr) begin
            rf_q[entry.rf_wr_addr] <= alu_out;
        end
    end

    // output register, second edge after the accept
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            result <= result_d;
        end
    end

endmodule

//--- data_path.sv
module data_path (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    input  stream_pe_pkg::stage_t                                  stage,
    input  stream_pe_pkg::cfg_entry_t [stream_pe_pkg::num_col-1:0] entries,
    input  stream_pe_pkg::rf_clear_t                               rf_clear,
    output stream_pe_pkg::stream_word_t                            stream_out,
    output logic                                                   stream_out_valid
);

    // one processing element per lane
    // the left neighbor of column 0 wraps around to the last column
    for (genvar c = 0; c < stream_pe_pkg::num_col; c++) begin : g_col
        pe_column pe_column_inst (
            .clk         (clk),
            .arst_n      (arst_n),
            .entry       (entries[c]),
            .lane        (stage.data[c]),
            .left_lane   (stage.data[(c + stream_pe_pkg::num_col - 1) % stream_pe_pkg::num_col]),
            .itr         (stage.itr),
            .stage_valid (stage.valid),
            .rf_clear    (rf_clear),
            .result      (stream_out[c])
        );
    end

    // valid follows the column output registers by the same single edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_out_valid <= 1'b0;
        end else begin
            stream_out_valid <= stage.valid;
        end
    end

endmodule

//--- stream_pe_top.sv
module stream_pe_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    // host configuration writes, only while ready is low
    input  stream_pe_pkg::cfg_wr_t                cfg_wr,
    // one-cycle pulse that opens a load phase
    input  logic                                  start_loader,
    input  logic [stream_pe_pkg::cfg_addr_w-1:0]  cfg_last_entry,
    input  logic [stream_pe_pkg::rf_addr_w:0]     rf_clear_count,
    input  stream_pe_pkg::stream_word_t           stream_in,
    // start is the per-beat strobe, ready is a level
    input  logic                                  start_stream_in,
    output logic                                  ready_stream_in,
    output stream_pe_pkg::stream_word_t           stream_out,
    output logic                                  stream_out_valid
);

    logic [stream_pe_pkg::cfg_addr_w-1:0]                 rd_addr;
    stream_pe_pkg::rf_clear_t                             rf_clear;
    stream_pe_pkg::stage_t                                stage;
    stream_pe_pkg::cfg_entry_t [stream_pe_pkg::num_col-1:0] entries;

    // producer, drives the table address and the beat stage
    stream_sequencer stream_sequencer_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .start_loader    (start_loader),
        .cfg_last_entry  (cfg_last_entry),
        .rf_clear_count  (rf_clear_count),
        .start_stream_in (start_stream_in),
        .stream_in       (stream_in),
        .ready_stream_in (ready_stream_in),
        .rd_addr         (rd_addr),
        .rf_clear        (rf_clear),
        .stage           (stage)
    );

    // buffer, one registered entry per column for the staged beat
    config_table config_table_inst (
        .clk     (clk),
        .cfg_wr  (cfg_wr),
        .rd_addr (rd_addr),
        .entries (entries)
    );

    // consumer, the columns and the output word
    data_path data_path_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .stage            (stage),
        .entries          (entries),
        .rf_clear         (rf_clear),
        .stream_out       (stream_out),
        .stream_out_valid (stream_out_valid)
    );

endmodule

//--- stream_pe_tb.sv
module stream_pe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                  clk;
    logic                                  arst_n;
    stream_pe_pkg::cfg_wr_t                cfg_wr;
    logic                                  start_loader;
    logic [stream_pe_pkg::cfg_addr_w-1:0]  cfg_last_entry;
    logic [stream_pe_pkg::rf_addr_w:0]     rf_clear_count;
    stream_pe_pkg::stream_word_t           stream_in;
    logic                                  start_stream_in;
    logic                                  ready_stream_in;
    stream_pe_pkg::stream_word_t           stream_out;
    logic                                  stream_out_valid;

    // reference model, a copy of the table, the register files and the counters
    stream_pe_pkg::cfg_entry_t tbl_m [stream_pe_pkg::num_col][stream_pe_pkg::cfg_depth];
    logic [stream_pe_pkg::lane_w-1:0] rf_m [stream_pe_pkg::num_col][stream_pe_pkg::rf_depth];
    logic [stream_pe_pkg::cfg_addr_w-1:0]  ptr_m;
    logic [stream_pe_pkg::cfg_addr_w-1:0]  last_m;
    logic [stream_pe_pkg::lane_w-1:0]      itr_m;
    // expected output words in accept order
    stream_pe_pkg::stream_word_t           exp_q [$];
    stream_pe_pkg::stream_word_t           exp_word;

    stream_pe_top stream_pe_top_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .cfg_wr           (cfg_wr),
        .start_loader     (start_loader),
        .cfg_last_entry   (cfg_last_entry),
        .rf_clear_count   (rf_clear_count),
        .stream_in        (stream_in),
        .start_stream_in  (start_stream_in),
        .ready_stream_in  (ready_stream_in),
        .stream_out       (stream_out),
        .stream_out_valid (stream_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name,
                               input logic [stream_pe_pkg::phit_size-1:0] actual,
                               input logic [stream_pe_pkg::phit_size-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [stream_pe_pkg::phit_size-1:0] widen_bit(input logic b);
        widen_bit = '0;
        widen_bit[0] = b;
    endfunction

    // any random entry is legal, every 2-bit code is a defined op and source
    function automatic stream_pe_pkg::cfg_entry_t random_entry();
        stream_pe_pkg::cfg_entry_t e;
        e = stream_pe_pkg::cfg_entry_t'(20'($urandom()));
        e.valid = 1'b1;
        return e;
    endfunction

    // a load pulse restarts the pass and zeroes the first rf_clear_count words
    task automatic model_load();
        last_m = cfg_last_entry;
        ptr_m = '0;
        itr_m = '0;
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            for (int a = 0; a < stream_pe_pkg::rf_depth; a++) begin
                if (a < int'(rf_clear_count)) begin
                    rf_m[c][a] = '0;
                end
            end
        end
    endtask

    task automatic model_beat(input stream_pe_pkg::stream_word_t din);
        stream_pe_pkg::stream_word_t      dout;
        stream_pe_pkg::cfg_entry_t        e;
        logic [stream_pe_pkg::lane_w-1:0] opnd;
        logic [stream_pe_pkg::lane_w-1:0] res;
        int                               left;
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            e = tbl_m[c][ptr_m];
            left = (c == 0) ? stream_pe_pkg::num_col - 1 : c - 1;
            opnd = '0;
            case (e.sel)
                stream_pe_pkg::sel_rf: opnd = rf_m[c][e.rf_rd_addr];
                stream_pe_pkg::sel_imm: opnd[stream_pe_pkg::imm_w-1:0] = e.imm;
                stream_pe_pkg::sel_itr: opnd = itr_m;
                default: opnd = din[left];
            endcase
            case (e.op)
                stream_pe_pkg::op_add: res = din[c] + opnd;
                stream_pe_pkg::op_sub: res = din[c] - opnd;
                stream_pe_pkg::op_xor: res = din[c] ^ opnd;
                default: res = opnd;
            endcase
            // the read above happens before this beat's own write-back
            dout[c] = e.valid ? res : din[c];
            if (e.valid && e.rf_wr_en) begin
                rf_m[c][e.rf_wr_addr] = res;
            end
        end
        exp_q.push_back(dout);
        if (ptr_m == last_m) begin
            ptr_m = '0;
            itr_m = itr_m + 1'b1;
        end else begin
            ptr_m = ptr_m + 1'b1;
        end
    endtask

    // inputs were driven at the last rising edge and hold until the next one
    always @(negedge clk) begin
        if (stream_out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("stream_out_valid was high with no beat outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                check_value("stream_out", stream_out, exp_word);
            end
        end
        if (start_loader) begin
            model_load();
        end else if (start_stream_in && ready_stream_in) begin
            model_beat(stream_in);
        end
    end

    task automatic write_entry(input logic [stream_pe_pkg::num_col-1:0] mask,
                               input logic [stream_pe_pkg::cfg_addr_w-1:0] addr,
                               input stream_pe_pkg::cfg_entry_t e);
        stream_pe_pkg::cfg_wr_t w;
        w.en = mask;
        w.addr = addr;
        w.entry = e;
        @(posedge clk);
        cfg_wr <= w;
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            if (mask[c]) begin
                tbl_m[c][addr] = e;
            end
        end
        @(negedge clk);
        if (ready_stream_in) begin
            abort_run("a host write was issued while ready_stream_in was high");
        end
    endtask

    task automatic end_writes();
        @(posedge clk);
        cfg_wr <= '0;
    endtask

    task automatic start_load(input logic [stream_pe_pkg::cfg_addr_w-1:0] last,
                              input logic [stream_pe_pkg::rf_addr_w:0] count);
        @(posedge clk);
        cfg_last_entry <= last;
        rf_clear_count <= count;
        start_loader <= 1'b1;
        @(posedge clk);
        start_loader <= 1'b0;
        // lower bound, ready drops for the clear phase
        @(negedge clk);
        check_value("ready_stream_in", widen_bit(ready_stream_in), '0);
    endtask

    task automatic wait_ready(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ready_stream_in) begin
            if (waited > limit) begin
                abort_run("ready_stream_in did not rise after the clear phase");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // gap is the percentage of cycles with start_stream_in low
    task automatic stream_beats(input int cycles, input int gap);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            stream_in <= stream_pe_pkg::stream_word_t'({$urandom(), $urandom()});
            start_stream_in <= ($urandom_range(99, 0) >= gap);
        end
        @(posedge clk);
        start_stream_in <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited > 8) begin
                abort_run("accepted beats never appeared on stream_out");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin
        stream_pe_pkg::cfg_entry_t       e0;
        stream_pe_pkg::cfg_entry_t       e1;
        stream_pe_pkg::cfg_entry_t       e2;
        logic [stream_pe_pkg::num_col-1:0] mask;
        void'($urandom(32'h5a56_03f0));
        arst_n = 1'b0;
        cfg_wr = '0;
        start_loader = 1'b0;
        cfg_last_entry = '0;
        rf_clear_count = '0;
        stream_in = '0;
        start_stream_in = 1'b0;
        ptr_m = '0;
        last_m = '0;
        itr_m = '0;
        for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
            for (int a = 0; a < stream_pe_pkg::rf_depth; a++) begin
                rf_m[c][a] = '0;
            end
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("ready_stream_in", widen_bit(ready_stream_in), '0);
        check_value("stream_out_valid", widen_bit(stream_out_valid), '0);

        // full table, each column sees every op and source pair once per pass
        for (int a = 0; a < stream_pe_pkg::cfg_depth; a++) begin
            for (int c = 0; c < stream_pe_pkg::num_col; c++) begin
                e0 = random_entry();
                e0.op = stream_pe_pkg::op_e'(a[1:0]);
                e0.sel = stream_pe_pkg::sel_e'(a[3:2]);
                mask = '0;
                mask[c] = 1'b1;
                write_entry(mask, a[stream_pe_pkg::cfg_addr_w-1:0], e0);
            end
        end
        end_writes();
        start_load(4'd15, 4'd8);
        wait_ready(10);
        stream_beats(200, 25);
        drain();

        // chained read and write-back on the same two words, back to back
        start_load(4'd3, 4'd5);
        for (int a = 0; a < 4; a++) begin
            e0 = random_entry();
            e0.sel = stream_pe_pkg::sel_rf;
            e0.rf_wr_en = 1'b1;
            e0.rf_rd_addr = 3'(a % 2);
            e0.rf_wr_addr = 3'($urandom_range(1, 0));
            write_entry('1, a[stream_pe_pkg::cfg_addr_w-1:0], e0);
        end
        end_writes();
        wait_ready(10);
        stream_beats(60, 0);
        drain();

        // short pass, the invalid middle entry must not touch word 5
        start_load(4'd2, 4'd4);
        e0 = random_entry();
        e0.op = stream_pe_pkg::op_pass;
        e0.sel = stream_pe_pkg::sel_itr;
        e0.rf_wr_en = 1'b1;
        e0.rf_wr_addr = 3'd5;
        e1 = random_entry();
        e1.valid = 1'b0;
        e1.rf_wr_en = 1'b1;
        e1.rf_wr_addr = 3'd5;
        e2 = random_entry();
        e2.op = stream_pe_pkg::op_xor;
        e2.sel = stream_pe_pkg::sel_rf;
        e2.rf_rd_addr = 3'd5;
        e2.rf_wr_en = 1'b0;
        write_entry('1, 4'd0, e0);
        write_entry('1, 4'd1, e1);
        write_entry('1, 4'd2, e2);
        end_writes();
        wait_ready(10);
        stream_beats(120, 10);
        drain();

        // full clear, register reads come back zero and itr starts over
        // word 5 still holds a nonzero count from the short pass until the clear
        start_load(4'd1, 4'd8);
        e0 = random_entry();
        e0.op = stream_pe_pkg::op_pass;
        e0.sel = stream_pe_pkg::sel_rf;
        e0.rf_rd_addr = 3'd5;
        e0.rf_wr_en = 1'b0;
        e1 = random_entry();
        e1.op = stream_pe_pkg::op_add;
        e1.sel = stream_pe_pkg::sel_itr;
        e1.rf_wr_en = 1'b0;
        write_entry('1, 4'd0, e0);
        write_entry('1, 4'd1, e1);
        end_writes();
        wait_ready(10);
        stream_beats(30, 20);
        drain();

        if (exp_q.size() != 0) begin
            abort_run("beats were still outstanding at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- stream_pe.f
stream_pe_pkg.sv
stream_sequencer.sv
config_table.sv
pe_column.sv
data_path.sv
stream_pe_top.sv
stream_pe_tb.sv

//--- Makefile
TOP   = stream_pe_tb
FLIST = stream_pe.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

obj_dir/V$(TOP): $(shell cat $(FLIST))
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

# the log decides the verdict, the simulator status is not trusted alone
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
